/* common/coreCfgPkg.sv */
package coreCfgPkg;

    localparam int dataWidth    = 32;
    localparam int regCount     = 16;
    localparam int regAddrWidth = $clog2(regCount);

    // Word address into the shared instruction and data memory
    localparam int memAddrWidth = 12;

    // Fixed five-step sequence per instruction
    typedef enum logic [2:0] {
        T0     = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T4     = 3'd4,
        HALTED = 3'd5
    } step_t;

endpackage

/* common/isaPkg.sv */
package isaPkg;

    // Opcode occupies the top five bits in both instruction forms
    typedef enum logic [4:0] {
        opOr   = 5'd0,
        opAnd  = 5'd1,
        opXor  = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opMul  = 5'd5,
        opMulh = 5'd6,
        opAddi = 5'd7,
        opOri  = 5'd8,
        opLw   = 5'd9,
        opSw   = 5'd10,
        opBrz  = 5'd11,
        opHalt = 5'd12
    } opcode_t;

    typedef enum logic [3:0] {
        aluOr    = 4'd0,
        aluAnd   = 4'd1,
        aluXor   = 4'd2,
        aluAdd   = 4'd3,
        aluSub   = 4'd4,
        aluMul   = 4'd5,
        aluPassB = 4'd6
    } aluCtrl_t;

    typedef struct packed {
        opcode_t                               opcode;
        logic [coreCfgPkg::regAddrWidth-1:0]   rd;
        logic [coreCfgPkg::regAddrWidth-1:0]   ra;
        logic [coreCfgPkg::regAddrWidth-1:0]   rb;
        logic [14:0]                           unused;
    } rForm_t;

    typedef struct packed {
        opcode_t                               opcode;
        logic [coreCfgPkg::regAddrWidth-1:0]   rd;
        logic [coreCfgPkg::regAddrWidth-1:0]   ra;
        logic signed [18:0]                    imm;
    } iForm_t;

    typedef union packed {
        rForm_t r;
        iForm_t i;
    } instr_t;

    function automatic logic [coreCfgPkg::dataWidth-1:0] signExtImm(iForm_t f);
        return {{(coreCfgPkg::dataWidth - 19){f.imm[18]}}, f.imm};
    endfunction

    function automatic logic [coreCfgPkg::dataWidth-1:0] zeroExtImm(iForm_t f);
        return {{(coreCfgPkg::dataWidth - 19){1'b0}}, f.imm};
    endfunction

    // Three-register ALU instructions
    function automatic logic isRegForm(opcode_t op);
        return op inside {opOr, opAnd, opXor, opAdd, opSub, opMul, opMulh};
    endfunction

    // Unknown opcodes stop the core as well
    function automatic logic isHalt(opcode_t op);
        return op >= opHalt;
    endfunction

endpackage

/* datapath/programCounter.sv */
`timescale 1ns/1ps

module programCounter (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic                                en,
    input  logic                                branch,
    input  logic [coreCfgPkg::memAddrWidth-1:0] offset,
    output logic [coreCfgPkg::memAddrWidth-1:0] pc
);

    // Branch offset is relative to the already incremented PC
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (branch) begin
            pc <= pc + offset;
        end else if (en) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic                                write,
    input  logic [coreCfgPkg::regAddrWidth-1:0] addrA,
    input  logic [coreCfgPkg::regAddrWidth-1:0] addrB,
    input  logic [coreCfgPkg::regAddrWidth-1:0] addrC,
    input  logic [coreCfgPkg::dataWidth-1:0]    wdata,
    output logic [coreCfgPkg::dataWidth-1:0]    rdataA,
    output logic [coreCfgPkg::dataWidth-1:0]    rdataB
);
    import coreCfgPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[addrC] <= wdata;
        end
    end

    // R0 is hardwired to zero on both read ports
    assign rdataA = (addrA == '0) ? '0 : regs[addrA];
    assign rdataB = (addrB == '0) ? '0 : regs[addrB];

    writeAddrKnown: assert property (@(posedge Clock) disable iff (!rstN)
        write |-> !$isunknown(addrC));

endmodule

/* datapath/alu.sv */
`timescale 1ns/1ps

module alu (
    input  isaPkg::aluCtrl_t                 ctrl,
    input  logic [coreCfgPkg::dataWidth-1:0] a,
    input  logic [coreCfgPkg::dataWidth-1:0] b,
    output logic [coreCfgPkg::dataWidth-1:0] resultLow,
    output logic [coreCfgPkg::dataWidth-1:0] resultHigh,
    output logic                             zero,
    output logic                             negative
);
    import isaPkg::*;
    import coreCfgPkg::*;

    logic signed [2*dataWidth-1:0] product;

    // Full signed product, high half only reaches RZH
    assign product = $signed(a) * $signed(b);

    always_comb begin
        resultHigh = '0;
        case (ctrl)
            aluOr:  resultLow = a | b;
            aluAnd: resultLow = a & b;
            aluXor: resultLow = a ^ b;
            aluAdd: resultLow = a + b;
            aluSub: resultLow = a - b;
            aluMul: begin
                resultLow  = product[dataWidth-1:0];
                resultHigh = product[2*dataWidth-1:dataWidth];
            end
            // aluPassB and any spare code
            default: resultLow = b;
        endcase
    end

    assign zero     = (resultLow == '0);
    assign negative = resultLow[dataWidth-1];

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [coreCfgPkg::dataWidth-1:0]    memRdata,
    input  logic                                pcEn,
    input  logic                                pcBranch,
    input  logic                                rfWrite,
    input  logic [coreCfgPkg::regAddrWidth-1:0] rfAddrA,
    input  logic [coreCfgPkg::regAddrWidth-1:0] rfAddrB,
    input  logic [coreCfgPkg::regAddrWidth-1:0] rfAddrC,
    input  logic                                raEn,
    input  logic                                rbEn,
    input  logic                                rzhEn,
    input  logic                                rzlEn,
    input  logic                                rwbEn,
    input  isaPkg::aluCtrl_t                    aluCtrl,
    input  logic                                bImmSel,
    input  logic                                rzHighSel,
    input  logic                                wbMemSel,
    input  logic                                memAddrPcSel,
    input  logic [coreCfgPkg::dataWidth-1:0]    imm32,
    output logic [coreCfgPkg::memAddrWidth-1:0] memAddr,
    output logic [coreCfgPkg::dataWidth-1:0]    memWdata,
    output logic                                aZero
);
    import coreCfgPkg::*;

    logic [memAddrWidth-1:0] pc;
    logic [dataWidth-1:0]    rfDataA;
    logic [dataWidth-1:0]    rfDataB;
    logic [dataWidth-1:0]    regA;
    logic [dataWidth-1:0]    regB;
    logic [dataWidth-1:0]    rzh;
    logic [dataWidth-1:0]    rzl;
    logic [dataWidth-1:0]    rwb;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    aluLow;
    logic [dataWidth-1:0]    aluHigh;
    logic [dataWidth-1:0]    wbData;

    programCounter progCounter (
        .Clock  (Clock),
        .rstN   (rstN),
        .en     (pcEn),
        .branch (pcBranch),
        .offset (imm32[memAddrWidth-1:0]),
        .pc     (pc)
    );

    regFile registers (
        .Clock  (Clock),
        .rstN   (rstN),
        .write  (rfWrite),
        .addrA  (rfAddrA),
        .addrB  (rfAddrB),
        .addrC  (rfAddrC),
        .wdata  (rwb),
        .rdataA (rfDataA),
        .rdataB (rfDataB)
    );

    assign aluB = bImmSel ? imm32 : regB;

    alu aluUnit (
        .ctrl       (aluCtrl),
        .a          (regA),
        .b          (aluB),
        .resultLow  (aluLow),
        .resultHigh (aluHigh),
        .zero       (),
        .negative   ()
    );

    // Memory load wins over either ALU half
    assign wbData = wbMemSel ? memRdata : (rzHighSel ? rzh : rzl);

    always_ff @(posedge Clock) begin
        if (raEn)
            regA <= rfDataA;
        if (rbEn)
            regB <= rfDataB;
        if (rzhEn)
            rzh <= aluHigh;
        if (rzlEn)
            rzl <= aluLow;
        if (rwbEn)
            rwb <= wbData;
    end

    assign memAddr  = memAddrPcSel ? pc : rzl[memAddrWidth-1:0];
    assign memWdata = regB;
    assign aZero    = (regA == '0);

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [coreCfgPkg::dataWidth-1:0]    memRdata,
    input  logic                                aZero,
    output logic                                halted,
    output logic                                memWrite,
    output logic                                pcEn,
    output logic                                pcBranch,
    output logic                                rfWrite,
    output logic [coreCfgPkg::regAddrWidth-1:0] rfAddrA,
    output logic [coreCfgPkg::regAddrWidth-1:0] rfAddrB,
    output logic [coreCfgPkg::regAddrWidth-1:0] rfAddrC,
    output logic                                raEn,
    output logic                                rbEn,
    output logic                                rzhEn,
    output logic                                rzlEn,
    output logic                                rwbEn,
    output isaPkg::aluCtrl_t                    aluCtrl,
    output logic                                bImmSel,
    output logic                                rzHighSel,
    output logic                                wbMemSel,
    output logic                                memAddrPcSel,
    output logic [coreCfgPkg::dataWidth-1:0]    imm32
);
    import isaPkg::*;
    import coreCfgPkg::*;

    step_t   step;
    step_t   stepNext;
    instr_t  fetched;
    instr_t  ir;
    opcode_t op;
    logic    isRegOp;
    logic    writesReg;
    logic    usesAlu;

    assign fetched = memRdata;

    always_ff @(posedge Clock) begin
        if (step == T0)
            ir <= fetched;
    end

    // HALT is caught straight out of fetch
    always_comb begin
        case (step)
            T0:      stepNext = isHalt(fetched.r.opcode) ? HALTED : T1;
            T1:      stepNext = T2;
            T2:      stepNext = T3;
            T3:      stepNext = T4;
            T4:      stepNext = T0;
            default: stepNext = HALTED;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            step <= T0;
        else
            step <= stepNext;
    end

    assign op        = ir.r.opcode;
    assign isRegOp   = isRegForm(op);
    assign writesReg = isRegOp || op inside {opAddi, opOri, opLw};
    assign usesAlu   = writesReg || op == opSw;

    // ra and rd sit at the same bits in both forms
    assign rfAddrA = ir.r.ra;
    // SW reads its source rd through port B
    assign rfAddrB = isRegOp ? ir.r.rb : ir.i.rd;
    assign rfAddrC = ir.r.rd;

    always_comb begin
        case (op)
            opOr, opOri:               aluCtrl = aluOr;
            opAnd:                     aluCtrl = aluAnd;
            opXor:                     aluCtrl = aluXor;
            opAdd, opAddi, opLw, opSw: aluCtrl = aluAdd;
            opSub:                     aluCtrl = aluSub;
            opMul, opMulh:             aluCtrl = aluMul;
            default:                   aluCtrl = aluPassB;
        endcase
    end

    assign imm32 = (op == opOri) ? zeroExtImm(ir.i) : signExtImm(ir.i);

    assign pcEn         = (step == T0);
    assign raEn         = (step == T1);
    assign rbEn         = (step == T1);
    assign rzhEn        = (step == T2) && usesAlu;
    assign rzlEn        = (step == T2) && usesAlu;
    assign pcBranch     = (step == T2) && op == opBrz && aZero;
    assign rwbEn        = (step == T3) && writesReg;
    assign memWrite     = (step == T3) && op == opSw;
    assign rfWrite      = (step == T4) && writesReg;
    assign bImmSel      = !isRegOp;
    assign rzHighSel    = (op == opMulh);
    assign wbMemSel     = (op == opLw);
    // Data access in T3 uses the address that RZL took in T2
    assign memAddrPcSel = (step != T3);
    assign halted       = (step == HALTED);

    // Register write always follows an RWB load in the step before
    rfWriteInT4: assert property (@(posedge Clock) disable iff (!rstN)
        rfWrite |-> step == T4 && $past(rwbEn));

    writesExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(memWrite && rfWrite));

endmodule

/* src/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic                                Clock,
    input  logic                                rstN,
    output logic [coreCfgPkg::memAddrWidth-1:0] memAddr,
    output logic [coreCfgPkg::dataWidth-1:0]    memWdata,
    output logic                                memWrite,
    input  logic [coreCfgPkg::dataWidth-1:0]    memRdata,
    output logic                                halted
);
    import isaPkg::*;
    import coreCfgPkg::*;

    // Control to datapath
    logic                    pcEn;
    logic                    pcBranch;
    logic                    rfWrite;
    logic [regAddrWidth-1:0] rfAddrA;
    logic [regAddrWidth-1:0] rfAddrB;
    logic [regAddrWidth-1:0] rfAddrC;
    logic                    raEn;
    logic                    rbEn;
    logic                    rzhEn;
    logic                    rzlEn;
    logic                    rwbEn;
    aluCtrl_t                aluCtrl;
    logic                    bImmSel;
    logic                    rzHighSel;
    logic                    wbMemSel;
    logic                    memAddrPcSel;
    logic [dataWidth-1:0]    imm32;

    // Branch condition back to control
    logic                    aZero;

    // Port names match the wires one to one
    controlUnit control (.*);

    datapath dpath (.*);

endmodule

/* sim/tbMemory.sv */
`timescale 1ns/1ps

module tbMemory (
    input  logic                                Clock,
    input  logic [coreCfgPkg::memAddrWidth-1:0] addr,
    input  logic [coreCfgPkg::dataWidth-1:0]    wdata,
    input  logic                                write,
    output logic [coreCfgPkg::dataWidth-1:0]    rdata
);
    import coreCfgPkg::*;

    localparam int depth = 1 << memAddrWidth;

    logic [dataWidth-1:0] mem     [depth];
    logic                 written [depth];
    int                   writeCount;

    // Same-cycle read, no wait states
    assign rdata = mem[addr];

    always @(posedge Clock) begin
        if (write) begin
            mem[addr]     <= wdata;
            written[addr] <= 1'b1;
            writeCount    <= writeCount + 1;
        end
    end

    task automatic loadWord(input int a, input logic [dataWidth-1:0] d);
        mem[a] = d;
    endtask

    // Forget the stores of the previous program
    task automatic clearLog();
        for (int a = 0; a < depth; a++) begin
            written[a] = 1'b0;
        end
        writeCount = 0;
    endtask

endmodule

/* sim/tbCpuCore.sv */
`timescale 1ns/1ps

module tbCpuCore;
    import isaPkg::*;
    import coreCfgPkg::*;

    localparam int memDepth   = 1 << memAddrWidth;
    localparam int dataBase   = 'h100;
    localparam int resultBase = 'h200;

    logic                    Clock;
    logic                    rstN;
    logic [memAddrWidth-1:0] memAddr;
    logic [dataWidth-1:0]    memWdata;
    logic                    memWrite;
    logic [dataWidth-1:0]    memRdata;
    logic                    halted;

    // Initial image, shared by the DUT memory and the reference model
    logic [dataWidth-1:0] image      [memDepth];
    logic [dataWidth-1:0] refMem     [memDepth];
    logic                 refWritten [memDepth];
    int                   refStores;
    int                   emitAt;
    int                   cycleCount;
    int                   cycleLimit;
    int                   testsRun;
    int                   testsFailed;
    int                   pinnedAddr;
    logic [dataWidth-1:0] pinnedValue;
    int                   loopCount;
    int                   negImm;

    cpuCore dut_i (
        .Clock    (Clock),
        .rstN     (rstN),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWrite (memWrite),
        .memRdata (memRdata),
        .halted   (halted)
    );

    tbMemory memory (
        .Clock (Clock),
        .addr  (memAddr),
        .wdata (memWdata),
        .write (memWrite),
        .rdata (memRdata)
    );

    initial begin
        Clock = 1'b0;
    end

    always #2 Clock = ~Clock;

    // Run budget grows as each test is set up
    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: halted did not rise within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic instr_t rInstr(opcode_t op, int rd, int ra, int rb);
        instr_t w;
        w = '0;
        w.r.opcode = op;
        w.r.rd     = regAddrWidth'(rd);
        w.r.ra     = regAddrWidth'(ra);
        w.r.rb     = regAddrWidth'(rb);
        return w;
    endfunction

    function automatic instr_t iInstr(opcode_t op, int rd, int ra, int imm);
        instr_t w;
        w = '0;
        w.i.opcode = op;
        w.i.rd     = regAddrWidth'(rd);
        w.i.ra     = regAddrWidth'(ra);
        w.i.imm    = 19'(imm);
        return w;
    endfunction

    // ISA interpreter, returns the number of instructions before HALT
    function automatic int runReference();
        logic [dataWidth-1:0]    regs [regCount];
        logic [memAddrWidth-1:0] pc;
        logic [memAddrWidth-1:0] ea;
        logic [dataWidth-1:0]    a;
        logic [dataWidth-1:0]    b;
        logic [dataWidth-1:0]    sImm;
        logic [dataWidth-1:0]    zImm;
        logic signed [63:0]      prod;
        instr_t                  ins;
        int                      count;
        logic                    running;
        for (int i = 0; i < memDepth; i++) begin
            refMem[i]     = image[i];
            refWritten[i] = 1'b0;
        end
        for (int i = 0; i < regCount; i++) begin
            regs[i] = '0;
        end
        refStores = 0;
        pc        = '0;
        count     = 0;
        running   = 1'b1;
        while (running && count < 10000) begin
            ins  = refMem[pc];
            pc   = pc + 1'b1;
            // ra sits at the same bits in both forms
            a    = regs[ins.r.ra];
            b    = regs[ins.r.rb];
            sImm = {{13{ins.i.imm[18]}}, ins.i.imm};
            zImm = {13'b0, ins.i.imm};
            prod = $signed(a) * $signed(b);
            ea   = memAddrWidth'(a + sImm);
            case (ins.r.opcode)
                opOr:   regs[ins.r.rd] = a | b;
                opAnd:  regs[ins.r.rd] = a & b;
                opXor:  regs[ins.r.rd] = a ^ b;
                opAdd:  regs[ins.r.rd] = a + b;
                opSub:  regs[ins.r.rd] = a - b;
                opMul:  regs[ins.r.rd] = prod[31:0];
                opMulh: regs[ins.r.rd] = prod[63:32];
                opAddi: regs[ins.i.rd] = a + sImm;
                opOri:  regs[ins.i.rd] = a | zImm;
                opLw:   regs[ins.i.rd] = refMem[ea];
                opSw: begin
                    refMem[ea]     = regs[ins.i.rd];
                    refWritten[ea] = 1'b1;
                    refStores++;
                end
                opBrz: begin
                    if (a == '0)
                        pc = pc + memAddrWidth'(sImm);
                end
                default: running = 1'b0;
            endcase
            if (running)
                count++;
            regs[0] = '0;
        end
        return count;
    endfunction

    // Fill pattern tied to every address bit
    task automatic startImage();
        for (int i = 0; i < memDepth; i++) begin
            image[i] = {8'h5a, 12'(i), 12'(~i)};
        end
        emitAt = 0;
    endtask

    task automatic emit(input instr_t w);
        image[emitAt] = w;
        emitAt++;
    endtask

    task automatic runTest(input string name);
        int   count;
        int   cycles;
        logic bad;
        count      = runReference();
        cycleLimit = cycleLimit + 5 * count + 50;
        @(posedge Clock);
        rstN <= 1'b0;
        @(negedge Clock);
        for (int i = 0; i < memDepth; i++) begin
            memory.loadWord(i, image[i]);
        end
        memory.clearLog();
        repeat (5) @(posedge Clock);
        rstN <= 1'b1;
        @(negedge Clock);
        cycles = 0;
        while (!halted) begin
            @(negedge Clock);
            cycles++;
        end
        bad = 1'b0;
        if (cycles != 5 * count + 1) begin
            $display("** Error %s: cycles to halt expected %0d actual %0d",
                     name, 5 * count + 1, cycles);
            bad = 1'b1;
        end
        if (memory.writeCount != refStores) begin
            $display("** Error %s: store count expected %0d actual %0d",
                     name, refStores, memory.writeCount);
            bad = 1'b1;
        end
        for (int i = 0; i < memDepth; i++) begin
            if (refWritten[i] && !memory.written[i]) begin
                $display("%s: no store reached address 0x%03h", name, i);
                bad = 1'b1;
            end else if (refWritten[i] && memory.mem[i] !== refMem[i]) begin
                $display("** Error %s: mem[0x%03h] expected 0x%08h actual 0x%08h",
                         name, i, refMem[i], memory.mem[i]);
                bad = 1'b1;
            end else if (memory.written[i] && !refWritten[i]) begin
                $display("%s: store to unexpected address 0x%03h", name, i);
                bad = 1'b1;
            end
        end
        if (pinnedAddr >= 0 && memory.mem[pinnedAddr] !== pinnedValue) begin
            $display("** Error %s: mem[0x%03h] expected 0x%08h actual 0x%08h",
                     name, pinnedAddr, pinnedValue, memory.mem[pinnedAddr]);
            bad = 1'b1;
        end
        testsRun++;
        if (bad) begin
            testsFailed++;
            $display("FAIL %s", name);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    initial begin
        rstN        = 1'b0;
        cycleCount  = 0;
        cycleLimit  = 0;
        testsRun    = 0;
        testsFailed = 0;
        pinnedAddr  = -1;
        pinnedValue = '0;
        void'($urandom(32'hbb8b));

        startImage();
        image[dataBase]     = 32'h22;
        image[dataBase + 1] = 32'h24;
        emit(iInstr(opLw, 3, 0, dataBase));
        emit(iInstr(opLw, 7, 0, dataBase + 1));
        emit(rInstr(opOr, 4, 3, 7));
        emit(iInstr(opSw, 4, 0, resultBase));
        emit(iInstr(opHalt, 0, 0, 0));
        pinnedAddr  = resultBase;
        pinnedValue = 32'h26;
        runTest("reference case");
        pinnedAddr = -1;

        startImage();
        image[dataBase]     = $urandom();
        image[dataBase + 1] = $urandom();
        emit(iInstr(opLw, 1, 0, dataBase));
        emit(iInstr(opLw, 2, 0, dataBase + 1));
        emit(rInstr(opOr, 3, 1, 2));
        emit(rInstr(opAnd, 4, 1, 2));
        emit(rInstr(opXor, 5, 1, 2));
        emit(rInstr(opAdd, 6, 1, 2));
        emit(rInstr(opSub, 7, 1, 2));
        for (int r = 3; r <= 7; r++) begin
            emit(iInstr(opSw, r, 0, resultBase + r));
        end
        emit(iInstr(opHalt, 0, 0, 0));
        runTest("random ALU ops");

        // First operand forced negative
        startImage();
        image[dataBase]     = $urandom() | 32'h8000_0000;
        image[dataBase + 1] = $urandom();
        emit(iInstr(opLw, 1, 0, dataBase));
        emit(iInstr(opLw, 2, 0, dataBase + 1));
        emit(rInstr(opMul, 3, 1, 2));
        emit(rInstr(opMulh, 4, 1, 2));
        emit(iInstr(opSw, 3, 0, resultBase));
        emit(iInstr(opSw, 4, 0, resultBase + 1));
        emit(iInstr(opHalt, 0, 0, 0));
        runTest("signed multiply");

        startImage();
        negImm = -1 - int'($urandom() % 4000);
        emit(iInstr(opAddi, 1, 0, negImm));
        emit(iInstr(opOri, 2, 0, 'h40000 | int'($urandom() % 'h40000)));
        emit(iInstr(opAddi, 3, 2, negImm));
        emit(iInstr(opSw, 1, 0, resultBase));
        emit(iInstr(opSw, 2, 0, resultBase + 1));
        emit(iInstr(opSw, 3, 0, resultBase + 2));
        emit(iInstr(opHalt, 0, 0, 0));
        runTest("immediate extension");

        // Countdown loop, then a BRZ on R0 jumps over a store
        startImage();
        loopCount      = 1 + int'($urandom() % 6);
        image[dataBase] = loopCount;
        emit(iInstr(opLw, 1, 0, dataBase));
        emit(iInstr(opAddi, 2, 0, 0));
        emit(iInstr(opBrz, 0, 1, 3));
        emit(iInstr(opAddi, 1, 1, -1));
        emit(iInstr(opAddi, 2, 2, 1));
        emit(iInstr(opBrz, 0, 0, -4));
        emit(iInstr(opSw, 2, 0, resultBase));
        emit(iInstr(opBrz, 0, 0, 1));
        emit(iInstr(opSw, 2, 0, resultBase + 1));
        emit(iInstr(opHalt, 0, 0, 0));
        runTest("branch loop");

        startImage();
        emit(iInstr(opHalt, 0, 0, 0));
        runTest("halt after reset");

        $display("%0d tests run, %0d passed, %0d failed",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: cpuCore

sources:
  - files:
      - common/coreCfgPkg.sv
      - common/isaPkg.sv
      - datapath/programCounter.sv
      - datapath/regFile.sv
      - datapath/alu.sv
      - datapath/datapath.sv
      - src/controlUnit.sv
      - src/cpuCore.sv
  - target: simulation
    files:
      - sim/tbMemory.sv
      - sim/tbCpuCore.sv

/* cpuCore.f */
common/coreCfgPkg.sv
common/isaPkg.sv
datapath/programCounter.sv
datapath/regFile.sv
datapath/alu.sv
datapath/datapath.sv
src/controlUnit.sv
src/cpuCore.sv
sim/tbMemory.sv
sim/tbCpuCore.sv
